// ==== files.f ====
verilog/hudPkg.sv
verilog/hudIfs.sv
verilog/pixelScanner.sv
verilog/lifeCounter.sv
verilog/lifeIconDraw.sv
verilog/iconBitmap.sv
verilog/lifeHudTop.sv
+incdir+sim
sim/lifeHudTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the lives display testbench with Verilator and run it from the project root
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module lifeHudTb -Mdir obj_dir -o lifeHudSim
./obj_dir/lifeHudSim | tee sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation reported errors, see sim.log"
	exit 1
fi
echo "simulation clean"

// ==== sim/hudRefModel.svh ====
`ifndef HUD_REF_MODEL_SVH
`define HUD_REF_MODEL_SVH

	localparam int REF_FRAME_W = 64;
	localparam int REF_FRAME_H = 24;
	localparam int REF_MAX_LIVES = 3;
	localparam int REF_HUD_X = 8; // left edge of icon 0
	localparam int REF_HUD_Y = 4; // top edge of all icons
	localparam int REF_PITCH = 18; // icon to icon step
	localparam logic [7:0] REF_ICON = 8'h6B;
	localparam logic [7:0] REF_BG = 8'h00;

	logic [15:0] refMask [0:15]; // heart rows, bit 15 is column 0
	int unsigned lcgState = 32'd58355; // fixed seed

	initial begin
		$readmemh("verilog/heartIcon.mem", refMask);
	end

	function automatic int unsigned nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState >> 8; // low bits of an LCG repeat too quickly
	endfunction

	// expected colour of screen pixel (x,y) with the given number of lives shown
	function automatic logic [7:0] expectedPixel(input int x, input int y, input int lives);
		int row;
		int left;
		logic found;
		logic [7:0] pixel;
		row = y - REF_HUD_Y;
		found = 1'b0;
		pixel = REF_BG; // background unless an opaque heart pixel
		for (int k = 0; k < REF_MAX_LIVES; k++) begin
			left = REF_HUD_X + k * REF_PITCH;
			if (!found && k < lives && row >= 0 && row < 16 && x >= left && x < left + 16) begin
				found = 1'b1; // lowest icon wins
				if (refMask[4'(row)][4'(15 - (x - left))])
					pixel = REF_ICON;
			end
		end
		return pixel;
	endfunction

`endif

// ==== sim/lifeHudTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lifeHudTb;

	localparam int TIMEOUT_CYCLES = 30000; // about 19 frames of 1536 cycles, with margin

	logic clk;
	logic resetN;
	logic enable;
	logic restart;
	logic dieReq;
	logic dieAck;
	logic [3:0] lifeCount;
	logic lostAllLives;
	logic [7:0] rgb;
	logic rgbValid;
	logic [10:0] outX;
	logic [10:0] outY;

	int errors = 0; // value and handshake errors
	int pixelErrors = 0; // rgb and raster mismatches from the compare process
	int testsRun = 0;
	int testsPassed = 0;
	int cycleCount = 0;
	int modelLives = 3; // count expected from the die and restart rules
	int framesChecked = 0;
	int frameLives = 0; // lives shown by the current output frame
	int lastFrameLives = -1; // lives of the last fully checked frame
	logic [3:0] lastLife = 4'd0;
	logic sinceOrigin = 1'b1; // lifeCount unchanged since the last origin output
	logic frameOk = 1'b0; // current output frame is trusted
	int scanX = 0; // next expected output column
	int scanY = 0; // next expected output row
	logic rasterOn = 1'b0; // output stream has started

	`include "hudRefModel.svh"

	lifeHudTop dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	// sampled mid-cycle, outputs settle on the rising edge
	always @(negedge clk) begin
		logic [7:0] expectedRgb;
		if (!resetN) begin
			lastLife = lifeCount;
			sinceOrigin = 1'b1;
			scanX = 0; // scanner restarts at the origin
			scanY = 0;
			rasterOn = 1'b0;
		end
		else begin
			if (lifeCount !== lastLife) begin
				sinceOrigin = 1'b0; // latch may hold either value
				frameOk = 1'b0;
				lastLife = lifeCount;
			end
			if (rgbValid && outX == 11'd0 && outY == 11'd0) begin
				frameOk = sinceOrigin; // frame latch lies between the two origins
				frameLives = int'(lifeCount);
				sinceOrigin = 1'b1;
			end
			if (rgbValid && frameOk) begin
				expectedRgb = expectedPixel(int'(outX), int'(outY), frameLives);
				if (rgb !== expectedRgb) begin
					$display("FAILED at %0t ns: rgb at (%0d,%0d) = %0h, expected %0h",
						$time, outX, outY, rgb, expectedRgb);
					pixelErrors++;
				end
				if (outX == 11'(REF_FRAME_W - 1) && outY == 11'(REF_FRAME_H - 1)) begin
					framesChecked++; // whole frame seen with a known count
					lastFrameLives = frameLives;
				end
			end
			if (rgbValid) begin
				if (outX !== 11'(scanX)) begin
					$display("FAILED at %0t ns: outX = %0d, expected %0d", $time, outX, scanX);
					pixelErrors++;
				end
				if (outY !== 11'(scanY)) begin
					$display("FAILED at %0t ns: outY = %0d, expected %0d", $time, outY, scanY);
					pixelErrors++;
				end
				rasterOn = 1'b1;
				if (int'(outX) == REF_FRAME_W - 1) begin
					scanX = 0; // row wraps
					scanY = (int'(outY) == REF_FRAME_H - 1) ? 0 : int'(outY) + 1;
				end
				else begin
					scanX = int'(outX) + 1;
					scanY = int'(outY);
				end
			end
			else if (rasterOn) begin
				$display("FAILED at %0t ns: rgbValid = 0, expected 1", $time);
				pixelErrors++;
			end
		end
	end

	task automatic reportWrong(input string name, input int actual, input int expected);
		$display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
		errors++;
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testsRun++;
		if (errors + pixelErrors == errorsBefore) begin
			testsPassed++;
			$display("test %0d %s: pass", testsRun, name);
		end
		else begin
			$display("test %0d %s: FAIL", testsRun, name);
		end
	endtask

	// four-phase die request, ack must rise then fall
	task automatic dieEvent();
		int waitCycles;
		if (dieAck !== 1'b0)
			reportWrong("dieAck", int'(dieAck), 0);
		dieReq = 1'b1;
		waitCycles = 0;
		while (dieAck !== 1'b1 && waitCycles < 16) begin
			@(posedge clk);
			#2;
			waitCycles++;
		end
		if (dieAck !== 1'b1) begin
			$display("handshake hang at %0t ns: dieAck never rose after dieReq", $time);
			errors++;
		end
		if (enable && modelLives > 0)
			modelLives--; // one life per accepted die
		if (lifeCount !== 4'(modelLives))
			reportWrong("lifeCount", int'(lifeCount), modelLives);
		if (lostAllLives !== (modelLives == 0))
			reportWrong("lostAllLives", int'(lostAllLives), int'(modelLives == 0));
		@(posedge clk); // request held one more cycle
		#2;
		if (dieAck !== 1'b1)
			reportWrong("dieAck", int'(dieAck), 1); // ack stays up while req is up
		if (lifeCount !== 4'(modelLives))
			reportWrong("lifeCount", int'(lifeCount), modelLives); // taken only once
		dieReq = 1'b0;
		waitCycles = 0;
		while (dieAck !== 1'b0 && waitCycles < 16) begin
			@(posedge clk);
			#2;
			waitCycles++;
		end
		if (dieAck !== 1'b0) begin
			$display("handshake hang at %0t ns: dieAck stayed high after dieReq fell", $time);
			errors++;
		end
	endtask

	task automatic restartPulse();
		restart = 1'b1;
		@(posedge clk);
		#2;
		restart = 1'b0;
		modelLives = REF_MAX_LIVES; // full lives again
		if (lifeCount !== 4'(modelLives))
			reportWrong("lifeCount", int'(lifeCount), modelLives);
		if (lostAllLives !== 1'b0)
			reportWrong("lostAllLives", int'(lostAllLives), 0);
	endtask

	// next fully checked frame must show the expected count
	task automatic waitFrame(input int lives);
		int startCount;
		startCount = framesChecked;
		while (framesChecked == startCount)
			@(posedge clk);
		#2;
		if (lastFrameLives != lives)
			reportWrong("frame lives", lastFrameLives, lives);
	endtask

	initial begin
		int errStart;
		int gap;
		resetN = 1'b0;
		enable = 1'b1;
		restart = 1'b0;
		dieReq = 1'b0;

		errStart = errors + pixelErrors;
		repeat (5) @(posedge clk);
		#2;
		if (lifeCount !== 4'd3)
			reportWrong("lifeCount", int'(lifeCount), 3);
		if (lostAllLives !== 1'b0)
			reportWrong("lostAllLives", int'(lostAllLives), 0);
		if (dieAck !== 1'b0)
			reportWrong("dieAck", int'(dieAck), 0);
		if (rgbValid !== 1'b0)
			reportWrong("rgbValid", int'(rgbValid), 0);
		repeat (5) @(posedge clk);
		#2;
		resetN = 1'b1; // 10 cycles of reset
		finishTest("reset state", errStart);

		errStart = errors + pixelErrors;
		waitFrame(3);
		finishTest("full lives frame", errStart);

		errStart = errors + pixelErrors;
		dieEvent();
		waitFrame(2);
		dieEvent();
		waitFrame(1);
		finishTest("die handshake", errStart);

		errStart = errors + pixelErrors;
		enable = 1'b0;
		dieEvent(); // acked, count stays
		enable = 1'b1;
		finishTest("enable gating", errStart);

		errStart = errors + pixelErrors;
		dieEvent();
		waitFrame(0); // background only
		dieEvent(); // nothing left to lose
		restartPulse();
		finishTest("lives exhausted", errStart);

		errStart = errors + pixelErrors;
		repeat (3) begin
			gap = int'(nextRandom() % 32'd1024);
			repeat (gap) @(posedge clk);
			#2;
			dieEvent();
			waitFrame(modelLives);
		end
		finishTest("random die timing", errStart);

		$display("tests %0d, passed %0d, value errors %0d, pixel errors %0d, frames checked %0d",
			testsRun, testsPassed, errors, pixelErrors, framesChecked);
		if (errors + pixelErrors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/heartIcon.mem ====
// heart mask, one 16-bit hex word per row from row 0 down, bit 15 is the left column
0000
3C3C
7E7E
FFFF
FFFF
FFFF
FFFF
7FFE
3FFC
1FF8
0FF0
07E0
03C0
0180
0000
0000

// ==== verilog/hudIfs.sv ====
`timescale 1ns/1ps
`default_nettype none

// raster position from the scanner, one pixel per clock, no back-pressure
interface scanIf import hudPkg::*; ();
	coordT pixelX; // current column
	coordT pixelY; // current row
	logic pixelValid; // scanner is running
	logic frameStart; // high with pixel (0,0)

	modport source (output pixelX, pixelY, pixelValid, frameStart);
	modport sink (input pixelX, pixelY, pixelValid, frameStart);
endinterface

// bracket result from the icon drawer, pixel position travels along
interface spriteIf import hudPkg::*; ();
	coordT offsetX; // column inside the icon
	coordT offsetY; // row inside the icon
	logic drawingRequest; // pixel lies inside a shown icon
	logic pixelValid; // word is a real pixel
	coordT pixelX; // screen column of this word
	coordT pixelY; // screen row of this word

	modport source (output offsetX, offsetY, drawingRequest, pixelValid, pixelX, pixelY);
	modport sink (input offsetX, offsetY, drawingRequest, pixelValid, pixelX, pixelY);
endinterface

`default_nettype wire

// ==== verilog/hudPkg.sv ====
`default_nettype none

package hudPkg;

	// raster coordinate, wide enough for a full 640x480 screen
	typedef logic [10:0] coordT; // unsigned pixel x or y

	// RGB332 colour word
	typedef logic [7:0] colorT; // rrr ggg bb

	// bitmap code for a see-through pixel
	localparam colorT TRANSPARENT = 8'hFF; // never reaches the screen

	// icons are square
	localparam int ICON_SIZE = 16; // width and height in pixels

	// heart mask, one 16-bit hex row per line, bit 15 is the left column
	localparam string MASK_FILE = "verilog/heartIcon.mem"; // relative to the run dir

endpackage

`default_nettype wire

// ==== verilog/iconBitmap.sv ====
`timescale 1ns/1ps
`default_nettype none

module iconBitmap import hudPkg::*; #(
	parameter colorT ICON_COLOR = 8'h6B,
	parameter colorT BG_COLOR = 8'h00
) (
	input logic clk,
	input logic resetN,
	spriteIf.sink sprite,
	output colorT rgb,
	output logic rgbValid,
	output coordT outX,
	output coordT outY
);

	logic [15:0] maskTable [0:ICON_SIZE-1]; // heart shape, row per word
	logic [15:0] maskRow;
	logic maskBit; // opaque pixel of the heart
	colorT iconPixel; // sprite layer alone
	colorT mergedPixel; // sprite over background

	initial begin
		$readmemh(MASK_FILE, maskTable);
	end

	assign maskRow = maskTable[sprite.offsetY[3:0]];
	assign maskBit = maskRow[4'(ICON_SIZE - 1) - sprite.offsetX[3:0]]; // bit 15 is column 0

	assign iconPixel = (sprite.drawingRequest && maskBit) ? ICON_COLOR : TRANSPARENT;

	// see-through pixels show the background
	assign mergedPixel = (iconPixel == TRANSPARENT) ? BG_COLOR : iconPixel;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			rgbValid <= 1'b0;
		else
			rgbValid <= sprite.pixelValid;
	end

	// colour and position leave together
	always_ff @(posedge clk) begin
		rgb <= mergedPixel;
		outX <= sprite.pixelX;
		outY <= sprite.pixelY;
	end

endmodule

`default_nettype wire

// ==== verilog/lifeCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module lifeCounter #(
	parameter int MAX_LIVES = 3
) (
	input logic clk,
	input logic resetN,
	input logic enable, // die events only count while high
	input logic restart, // reload full lives, wins over a die
	input logic dieReq, // four-phase request from the game
	output logic dieAck,
	output logic [3:0] lifeCount,
	output logic lostAllLives
);

	logic dieAccept; // new request, not yet acknowledged
	logic [3:0] nextCount;

	// a request is taken once, on the edge where ack is still low
	assign dieAccept = dieReq && !dieAck;

	always_comb begin
		nextCount = lifeCount;
		if (restart)
			nextCount = 4'(MAX_LIVES); // priority over the die event
		else if (dieAccept && enable && lifeCount != 4'd0)
			nextCount = lifeCount - 4'd1; // one life per accepted die
	end

	// ack follows the request by one clock, which gives the four phases:
	// req up -> ack up (count updated on the same edge) -> req down -> ack down
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			lifeCount <= 4'(MAX_LIVES);
			dieAck <= 1'b0;
		end
		else begin
			lifeCount <= nextCount;
			dieAck <= dieReq; // also acks when gated or already at zero
		end
	end

	// set exactly while the count sits at zero
	assign lostAllLives = (lifeCount == 4'd0);

endmodule

`default_nettype wire

// ==== verilog/lifeHudTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module lifeHudTop import hudPkg::*; #(
	parameter int FRAME_W = 64,
	parameter int FRAME_H = 24,
	parameter int MAX_LIVES = 3,
	parameter int HUD_X = 8,
	parameter int HUD_Y = 4,
	parameter int ICON_PITCH = 18,
	parameter colorT ICON_COLOR = 8'h6B,
	parameter colorT BG_COLOR = 8'h00
) (
	input logic clk,
	input logic resetN,
	input logic enable,
	input logic restart,
	input logic dieReq,
	output logic dieAck,
	output logic [3:0] lifeCount,
	output logic lostAllLives,
	output colorT rgb, // two clocks behind the scanner
	output logic rgbValid,
	output coordT outX,
	output coordT outY
);

	scanIf scanBus (); // scanner to drawer
	spriteIf spriteBus (); // drawer to bitmap

	pixelScanner #(
		.FRAME_W (FRAME_W),
		.FRAME_H (FRAME_H)
	) scanner0 (
		.clk (clk),
		.resetN (resetN),
		.scan (scanBus.source)
	);

	lifeCounter #(
		.MAX_LIVES (MAX_LIVES)
	) counter0 (
		.clk (clk),
		.resetN (resetN),
		.enable (enable),
		.restart (restart),
		.dieReq (dieReq),
		.dieAck (dieAck),
		.lifeCount (lifeCount),
		.lostAllLives (lostAllLives)
	);

	lifeIconDraw #(
		.MAX_LIVES (MAX_LIVES),
		.HUD_X (HUD_X),
		.HUD_Y (HUD_Y),
		.ICON_PITCH (ICON_PITCH)
	) draw0 (
		.clk (clk),
		.resetN (resetN),
		.lifeCount (lifeCount),
		.scan (scanBus.sink),
		.sprite (spriteBus.source)
	);

	iconBitmap #(
		.ICON_COLOR (ICON_COLOR),
		.BG_COLOR (BG_COLOR)
	) bitmap0 (
		.clk (clk),
		.resetN (resetN),
		.sprite (spriteBus.sink),
		.rgb (rgb),
		.rgbValid (rgbValid),
		.outX (outX),
		.outY (outY)
	);

endmodule

`default_nettype wire

// ==== verilog/lifeIconDraw.sv ====
`timescale 1ns/1ps
`default_nettype none

module lifeIconDraw import hudPkg::*; #(
	parameter int MAX_LIVES = 3,
	parameter int HUD_X = 8,
	parameter int HUD_Y = 4,
	parameter int ICON_PITCH = 18
) (
	input logic clk,
	input logic resetN,
	input logic [3:0] lifeCount,
	scanIf.sink scan,
	spriteIf.source sprite
);

	logic [3:0] livesLatched; // count frozen at frame start
	logic [3:0] livesNow; // count used for the current pixel
	logic inRow; // pixel is on the icon rows
	logic hit; // some shown icon covers the pixel
	coordT hitOffX;
	coordT hitOffY;

	// left edge of icon k
	function automatic int iconLeft(input int k);
		return HUD_X + k * ICON_PITCH;
	endfunction

	// the origin pixel itself already sees the fresh count
	assign livesNow = scan.frameStart ? lifeCount : livesLatched;
	assign inRow = (int'(scan.pixelY) >= HUD_Y) && (int'(scan.pixelY) < HUD_Y + ICON_SIZE);

	// lowest matching index wins, icons past the live count stay hidden
	always_comb begin
		hit = 1'b0;
		hitOffX = '0; // no icon, zero offsets
		hitOffY = '0;
		for (int k = 0; k < MAX_LIVES; k++) begin
			if (!hit && inRow && k < int'(livesNow)
					&& int'(scan.pixelX) >= iconLeft(k)
					&& int'(scan.pixelX) < iconLeft(k) + ICON_SIZE) begin
				hit = 1'b1;
				hitOffX = coordT'(int'(scan.pixelX) - iconLeft(k)); // from top-left corner
				hitOffY = coordT'(int'(scan.pixelY) - HUD_Y);
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			livesLatched <= 4'(MAX_LIVES);
			sprite.drawingRequest <= 1'b0;
			sprite.pixelValid <= 1'b0;
		end
		else begin
			if (scan.pixelValid && scan.frameStart)
				livesLatched <= lifeCount; // held for the whole frame
			sprite.drawingRequest <= scan.pixelValid && hit;
			sprite.pixelValid <= scan.pixelValid;
		end
	end

	// payload, qualified by pixelValid
	always_ff @(posedge clk) begin
		sprite.offsetX <= hitOffX;
		sprite.offsetY <= hitOffY;
		sprite.pixelX <= scan.pixelX;
		sprite.pixelY <= scan.pixelY;
	end

endmodule

`default_nettype wire

// ==== verilog/pixelScanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixelScanner import hudPkg::*; #(
	parameter int FRAME_W = 64,
	parameter int FRAME_H = 24
) (
	input logic clk,
	input logic resetN,
	scanIf.source scan
);

	logic lastX; // on the right-most column
	logic lastY; // on the bottom row

	assign lastX = (scan.pixelX == coordT'(FRAME_W - 1));
	assign lastY = (scan.pixelY == coordT'(FRAME_H - 1));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			scan.pixelX <= '0;
			scan.pixelY <= '0;
			scan.pixelValid <= 1'b0;
			scan.frameStart <= 1'b0;
		end
		else if (!scan.pixelValid) begin
			scan.pixelValid <= 1'b1; // first clock out of reset shows the origin
			scan.frameStart <= 1'b1;
		end
		else begin
			scan.frameStart <= lastX && lastY; // next pixel wraps to (0,0)
			if (lastX) begin
				scan.pixelX <= '0;
				if (lastY)
					scan.pixelY <= '0; // end of frame
				else
					scan.pixelY <= scan.pixelY + coordT'(1);
			end
			else begin
				scan.pixelX <= scan.pixelX + coordT'(1);
			end
		end
	end

endmodule

`default_nettype wire
